// File: Bender.yml
package:
  name: csr_unit

sources:
  - hdl/core_cfg_pkg.sv
  - hdl/riscv_csr_pkg.sv
  - hdl/csr_req_if.sv
  - hdl/csr_decode.sv
  - hdl/csr_file.sv
  - hdl/csr_writeback.sv
  - hdl/csr_unit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/csr_unit_tb.sv

// File: csr_unit.f
+incdir+verification
hdl/core_cfg_pkg.sv
hdl/riscv_csr_pkg.sv
hdl/csr_req_if.sv
hdl/csr_decode.sv
hdl/csr_file.sv
hdl/csr_writeback.sv
hdl/csr_unit.sv
verification/csr_unit_tb.sv

// File: hdl/core_cfg_pkg.sv
package core_cfg_pkg;

  // misa and the counter split assume rv32
  localparam int unsigned xlen = 32;

  localparam int unsigned csr_addr_width = 12;
  localparam int unsigned reg_idx_width = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [csr_addr_width-1:0] csr_addr_t;
  typedef logic [reg_idx_width-1:0] reg_idx_t;

endpackage

// File: hdl/csr_decode.sv
`timescale 1ns/1ps

module csr_decode
  import core_cfg_pkg::*;
  import riscv_csr_pkg::*;
(
  input  logic        clk,
  input  logic        nrst,
  input  logic        i_valid,
  input  word_t       i_inst,
  input  word_t       i_rs1_data,
  csr_req_if.producer o_req
);

  logic [6:0] opcode;
  csr_op_t funct3;
  reg_idx_t rs1_field;
  logic is_csr;
  logic imm_form;
  logic write_en;
  word_t operand;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign rs1_field = i_inst[19:15];

  assign is_csr = i_valid && (opcode == opcode_system) && (funct3 != '0);
  assign imm_form = funct3[2];
  assign operand = imm_form ? word_t'(rs1_field) : i_rs1_data; // uimm zero-extended

  // set and clear with x0 or a zero uimm must not write
  always_comb begin
    case (funct3)
      funct3_csrrw, funct3_csrrwi: write_en = 1'b1;
      default: write_en = (rs1_field != '0);
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_req.valid <= 1'b0;
    end else begin
      o_req.valid <= is_csr;
    end
  end

  // payload only moves on an accepted instruction
  always_ff @(posedge clk) begin
    if (is_csr) begin
      o_req.op <= funct3;
      o_req.addr <= i_inst[31:20];
      o_req.wdata <= operand;
      o_req.we <= write_en;
      o_req.rd <= i_inst[11:7];
    end
  end

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file
  import core_cfg_pkg::*;
  import riscv_csr_pkg::*;
#(
  parameter word_t hart_id = '0
) (
  input  logic        clk,
  input  logic        nrst,
  input  logic [63:0] i_rtc,
  input  logic        i_retire,
  csr_req_if.file     i_req,
  output word_t       o_rdata,
  output logic        o_unimpl
);

  localparam logic [1:0] misa_mxl = 2'd1; // rv32
  localparam word_t misa_value =
    (word_t'(misa_mxl) << (xlen - 2)) | (word_t'(1) << misa_ext_m);

  logic [63:0] mcycle;
  logic [63:0] minstret;

  // implemented mstatus fields
  logic status_sum;
  logic [1:0] status_mpp;
  logic status_spp;
  logic status_mpie;
  logic status_spie;
  logic status_mie;
  logic status_sie;

  word_t mtvec;
  word_t mscratch;
  word_t mstatus_value;
  word_t new_value;
  logic wr;

  always_comb begin
    mstatus_value = '0;
    mstatus_value[mstatus_sum] = status_sum;
    mstatus_value[mstatus_mpp_hi:mstatus_mpp_lo] = status_mpp;
    mstatus_value[mstatus_spp] = status_spp;
    mstatus_value[mstatus_mpie] = status_mpie;
    mstatus_value[mstatus_spie] = status_spie;
    mstatus_value[mstatus_mie] = status_mie;
    mstatus_value[mstatus_sie] = status_sie;
  end

  always_comb begin
    o_unimpl = 1'b0;
    case (i_req.addr)
      csr_addr_time: o_rdata = i_rtc[31:0];
      csr_addr_timeh: o_rdata = i_rtc[63:32];
      csr_addr_cycle: o_rdata = mcycle[31:0];
      csr_addr_cycleh: o_rdata = mcycle[63:32];
      csr_addr_instret: o_rdata = minstret[31:0];
      csr_addr_instreth: o_rdata = minstret[63:32];
      csr_addr_mstatus: o_rdata = mstatus_value;
      csr_addr_mstatush: o_rdata = '0; // no big-endian support
      csr_addr_mtvec: o_rdata = mtvec;
      csr_addr_mscratch: o_rdata = mscratch;
      csr_addr_mhartid: o_rdata = hart_id;
      csr_addr_misa: o_rdata = misa_value;
      default: begin
        o_rdata = '0;
        o_unimpl = 1'b1;
      end
    endcase
  end

  always_comb begin
    case (i_req.op)
      funct3_csrrs, funct3_csrrsi: new_value = o_rdata | i_req.wdata;
      funct3_csrrc, funct3_csrrci: new_value = o_rdata & ~i_req.wdata;
      default: new_value = i_req.wdata;
    endcase
  end

  assign wr = i_req.valid && i_req.we;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      mcycle <= '0;
      minstret <= '0;
    end else begin
      mcycle <= mcycle + 64'd1;
      if (i_retire) begin
        minstret <= minstret + 64'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      status_sum <= 1'b0;
      status_mpp <= priv_mode_m;
      status_spp <= priv_mode_s[0];
      status_mpie <= 1'b0;
      status_spie <= 1'b0;
      status_mie <= 1'b0;
      status_sie <= 1'b0;
    end else if (wr && i_req.addr == csr_addr_mstatus) begin
      status_sum <= new_value[mstatus_sum];
      status_mpp <= new_value[mstatus_mpp_hi:mstatus_mpp_lo];
      status_spp <= new_value[mstatus_spp];
      status_mpie <= new_value[mstatus_mpie];
      status_spie <= new_value[mstatus_spie];
      status_mie <= new_value[mstatus_mie];
      status_sie <= new_value[mstatus_sie];
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      mtvec <= '0;
      mscratch <= '0;
    end else if (wr) begin
      if (i_req.addr == csr_addr_mtvec) begin
        mtvec <= new_value;
      end
      if (i_req.addr == csr_addr_mscratch) begin
        mscratch <= new_value;
      end
    end
  end

endmodule

// File: hdl/csr_req_if.sv
`timescale 1ns/1ps

interface csr_req_if
  import core_cfg_pkg::*;
  import riscv_csr_pkg::*;
();

  logic valid;   // one cycle per request
  csr_op_t op;
  csr_addr_t addr;
  word_t wdata;  // rs1 value or zero-extended uimm
  logic we;
  reg_idx_t rd;

  modport producer (
    output valid, op, addr, wdata, we, rd
  );

  modport file (
    input valid, op, addr, wdata, we
  );

  modport result (
    input valid, rd
  );

endinterface

// File: hdl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
  import core_cfg_pkg::*;
#(
  parameter word_t hart_id = '0
) (
  input  logic        clk,
  input  logic        nrst,
  input  logic        i_valid,
  input  word_t       i_inst,
  input  word_t       i_rs1_data,
  input  logic [63:0] i_rtc,
  input  logic        i_retire,
  output logic        o_rd_valid,
  output reg_idx_t    o_rd_addr,
  output word_t       o_rd_data,
  output logic        o_illegal
);

  word_t rdata;
  logic unimpl;

  csr_req_if req_if ();

  csr_decode decode_i (
    .clk        (clk),
    .nrst       (nrst),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_rs1_data (i_rs1_data),
    .o_req      (req_if.producer)
  );

  csr_file #(
    .hart_id (hart_id)
  ) file_i (
    .clk      (clk),
    .nrst     (nrst),
    .i_rtc    (i_rtc),
    .i_retire (i_retire),
    .i_req    (req_if.file),
    .o_rdata  (rdata),
    .o_unimpl (unimpl)
  );

  csr_writeback writeback_i (
    .clk        (clk),
    .nrst       (nrst),
    .i_req      (req_if.result),
    .i_rdata    (rdata),
    .i_unimpl   (unimpl),
    .o_rd_valid (o_rd_valid),
    .o_rd_addr  (o_rd_addr),
    .o_rd_data  (o_rd_data),
    .o_illegal  (o_illegal)
  );

endmodule

// File: hdl/csr_writeback.sv
`timescale 1ns/1ps

module csr_writeback
  import core_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  csr_req_if.result i_req,
  input  word_t     i_rdata,
  input  logic      i_unimpl,
  output logic      o_rd_valid,
  output reg_idx_t  o_rd_addr,
  output word_t     o_rd_data,
  output logic      o_illegal
);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_rd_valid <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_rd_valid <= i_req.valid;
      o_illegal <= i_req.valid && i_unimpl;
    end
  end

  always_ff @(posedge clk) begin
    if (i_req.valid) begin
      o_rd_addr <= i_req.rd;
      // x0 always gets zero
      o_rd_data <= (i_req.rd == '0) ? '0 : i_rdata;
    end
  end

endmodule

// File: hdl/riscv_csr_pkg.sv
package riscv_csr_pkg;
  import core_cfg_pkg::*;

  localparam logic [6:0] opcode_system = 7'b1110011;

  // funct3 of the zicsr instructions
  typedef logic [2:0] csr_op_t;

  localparam csr_op_t funct3_csrrw = 3'b001;
  localparam csr_op_t funct3_csrrs = 3'b010;
  localparam csr_op_t funct3_csrrc = 3'b011;
  localparam csr_op_t funct3_csrrwi = 3'b101;
  localparam csr_op_t funct3_csrrsi = 3'b110;
  localparam csr_op_t funct3_csrrci = 3'b111;

  // unprivileged read-only counters
  localparam csr_addr_t csr_addr_cycle = 12'hc00;
  localparam csr_addr_t csr_addr_time = 12'hc01;
  localparam csr_addr_t csr_addr_instret = 12'hc02;
  localparam csr_addr_t csr_addr_cycleh = 12'hc80;
  localparam csr_addr_t csr_addr_timeh = 12'hc81;
  localparam csr_addr_t csr_addr_instreth = 12'hc82;

  // machine level
  localparam csr_addr_t csr_addr_mstatus = 12'h300;
  localparam csr_addr_t csr_addr_misa = 12'h301;
  localparam csr_addr_t csr_addr_mtvec = 12'h305;
  localparam csr_addr_t csr_addr_mstatush = 12'h310;
  localparam csr_addr_t csr_addr_mscratch = 12'h340;
  localparam csr_addr_t csr_addr_mhartid = 12'hf14;

  localparam logic [1:0] priv_mode_s = 2'b01;
  localparam logic [1:0] priv_mode_m = 2'b11;

  // mstatus bit positions
  localparam int unsigned mstatus_sie = 1;
  localparam int unsigned mstatus_mie = 3;
  localparam int unsigned mstatus_spie = 5;
  localparam int unsigned mstatus_mpie = 7;
  localparam int unsigned mstatus_spp = 8;
  localparam int unsigned mstatus_mpp_lo = 11;
  localparam int unsigned mstatus_mpp_hi = 12;
  localparam int unsigned mstatus_sum = 18;

  localparam int unsigned misa_ext_m = 12; // index of the letter m

endpackage

// File: verification/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

typedef struct packed {
  csr_addr_t addr;
  reg_idx_t rd;
  word_t data;
  logic illegal;
} result_t;

// SUM, MPP, SPP, MPIE, SPIE, MIE, SIE
localparam word_t mstatus_mask = 32'h0004_19aa;
localparam word_t mstatus_reset = 32'h0000_1900; // MPP machine, SPP set
localparam word_t misa_rv32m = 32'h4000_1000;

result_t exp_q[$];

logic [63:0] m_cycle;
logic [63:0] m_instret;
word_t m_mstatus;
word_t m_mtvec;
word_t m_mscratch;

// request held between decode and the register file
logic s1_valid;
csr_op_t s1_op;
csr_addr_t s1_addr;
word_t s1_wdata;
logic s1_we;
reg_idx_t s1_rd;

task automatic model_reset();
  m_cycle = '0;
  m_instret = '0;
  m_mstatus = mstatus_reset;
  m_mtvec = '0;
  m_mscratch = '0;
  s1_valid = 1'b0;
endtask

function automatic word_t model_read(input csr_addr_t addr, input logic [63:0] rtc,
                                     output logic unimpl);
  unimpl = 1'b0;
  case (addr)
    csr_addr_time: return rtc[31:0];
    csr_addr_timeh: return rtc[63:32];
    csr_addr_cycle: return m_cycle[31:0];
    csr_addr_cycleh: return m_cycle[63:32];
    csr_addr_instret: return m_instret[31:0];
    csr_addr_instreth: return m_instret[63:32];
    csr_addr_mstatus: return m_mstatus;
    csr_addr_mstatush: return '0;
    csr_addr_mtvec: return m_mtvec;
    csr_addr_mscratch: return m_mscratch;
    csr_addr_mhartid: return tb_hart_id;
    csr_addr_misa: return misa_rv32m;
    default: unimpl = 1'b1;
  endcase
  return '0;
endfunction

// one rising edge, given the inputs that were sampled at it
task automatic model_edge(input logic rst_n, input logic valid, input word_t inst,
                          input word_t rs1, input logic [63:0] rtc, input logic retire);
  word_t old;
  word_t nv;
  logic unimpl;
  result_t r;
  if (!rst_n) begin
    model_reset();
  end else begin
    if (s1_valid) begin
      old = model_read(s1_addr, rtc, unimpl);
      r.addr = s1_addr;
      r.rd = s1_rd;
      r.data = (s1_rd == 5'd0) ? 32'h0 : old;
      r.illegal = unimpl;
      exp_q.push_back(r);
      case (s1_op)
        funct3_csrrs, funct3_csrrsi: nv = old | s1_wdata;
        funct3_csrrc, funct3_csrrci: nv = old & ~s1_wdata;
        default: nv = s1_wdata;
      endcase
      if (s1_we) begin
        case (s1_addr)
          csr_addr_mstatus: m_mstatus = nv & mstatus_mask;
          csr_addr_mtvec: m_mtvec = nv;
          csr_addr_mscratch: m_mscratch = nv;
          default: ;  // read-only or absent
        endcase
      end
    end
    m_cycle = m_cycle + 64'd1;
    if (retire) begin
      m_instret = m_instret + 64'd1;
    end
    s1_valid = valid && (inst[6:0] == opcode_system) && (inst[14:12] != 3'b000);
    s1_op = inst[14:12];
    s1_addr = inst[31:20];
    s1_wdata = inst[14] ? word_t'(inst[19:15]) : rs1;
    s1_we = (s1_op == funct3_csrrw) || (s1_op == funct3_csrrwi) || (inst[19:15] != 5'd0);
    s1_rd = inst[11:7];
  end
endtask

`endif

// File: verification/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
  import core_cfg_pkg::*;
  import riscv_csr_pkg::*;
();

  localparam word_t tb_hart_id = 32'h0000_0007;
  localparam int unsigned num_requests = 2000;
  localparam int unsigned max_cycles = 20000;
  localparam int unsigned drain_limit = 20;

  logic clk;
  logic nrst;
  logic i_valid;
  word_t i_inst;
  word_t i_rs1_data;
  logic [63:0] i_rtc;
  logic i_retire;
  logic o_rd_valid;
  reg_idx_t o_rd_addr;
  word_t o_rd_data;
  logic o_illegal;
  int unsigned sent;
  int unsigned cycles;

  `include "csr_model.svh"

  csr_unit #(
    .hart_id (tb_hart_id)
  ) dut_i (
    .clk        (clk),
    .nrst       (nrst),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_rs1_data (i_rs1_data),
    .i_rtc      (i_rtc),
    .i_retire   (i_retire),
    .o_rd_valid (o_rd_valid),
    .o_rd_addr  (o_rd_addr),
    .o_rd_data  (o_rd_data),
    .o_illegal  (o_illegal)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    $display("error: %s expected %h actual %h", name, expected, actual);
    $display("Simulation failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  function automatic word_t random_inst();
    csr_op_t op;
    csr_addr_t addr;
    reg_idx_t src;
    reg_idx_t rd;
    logic [6:0] opcode;
    case ($urandom_range(5, 0))
      0: op = funct3_csrrw;
      1: op = funct3_csrrs;
      2: op = funct3_csrrc;
      3: op = funct3_csrrwi;
      4: op = funct3_csrrsi;
      default: op = funct3_csrrci;
    endcase
    case ($urandom_range(19, 0))
      0: addr = csr_addr_time;
      1: addr = csr_addr_timeh;
      2: addr = csr_addr_cycle;
      3: addr = csr_addr_cycleh;
      4: addr = csr_addr_instret;
      5: addr = csr_addr_instreth;
      6: addr = csr_addr_mstatush;
      7: addr = csr_addr_mhartid;
      8: addr = csr_addr_misa;
      9, 10, 11: addr = csr_addr_mstatus;
      12, 13, 14: addr = csr_addr_mtvec;
      15, 16: addr = csr_addr_mscratch;
      default: addr = csr_addr_t'($urandom);  // mostly unimplemented
    endcase
    src = ($urandom_range(2, 0) == 0) ? 5'd0 : reg_idx_t'($urandom);
    rd = ($urandom_range(7, 0) == 0) ? 5'd0 : reg_idx_t'($urandom);
    opcode = ($urandom_range(15, 0) == 0) ? 7'b0110011 : opcode_system; // some non-CSR
    return {addr, src, op, rd, opcode};
  endfunction

  task automatic check_outputs();
    result_t exp;
    if (o_rd_valid) begin
      assert (exp_q.size() > 0) else begin
        report_error("o_rd_valid pulsed with no request outstanding");
      end
      exp = exp_q.pop_front();
      assert (o_rd_data === exp.data) else begin
        report_mismatch($sformatf("rd_data csr %h", exp.addr), exp.data, o_rd_data);
      end
      assert (o_rd_addr === exp.rd) else begin
        report_mismatch($sformatf("rd_addr csr %h", exp.addr), word_t'(exp.rd),
                        word_t'(o_rd_addr));
      end
      assert (o_illegal === exp.illegal) else begin
        report_mismatch($sformatf("illegal csr %h", exp.addr), word_t'(exp.illegal),
                        word_t'(o_illegal));
      end
    end else begin
      assert (o_rd_valid === 1'b0 && exp_q.size() == 0) else begin
        report_error("o_rd_valid not high two cycles after a request");
      end
      assert (o_illegal === 1'b0) else begin
        report_error("o_illegal raised without a result");
      end
    end
  endtask

  // model and check just after the edge, then drive 2 ns after it
  task automatic advance_cycle();
    @(posedge clk);
    #1;
    model_edge(nrst, i_valid, i_inst, i_rs1_data, i_rtc, i_retire);
    check_outputs();
    #1;
  endtask

  initial begin
    void'($urandom(85801));
    nrst = 1'b0;
    i_valid = 1'b0;
    i_inst = '0;
    i_rs1_data = '0;
    i_rtc = '0;
    i_retire = 1'b0;
    sent = 0;
    repeat (3) advance_cycle();
    nrst = 1'b1;
    for (cycles = 0; cycles < max_cycles && sent < num_requests; cycles++) begin
      i_retire = ($urandom_range(1, 0) != 0);
      i_valid = ($urandom_range(3, 0) != 0);
      if (i_valid) begin
        i_inst = random_inst();
        i_rs1_data = $urandom;
        i_rtc = {$urandom, $urandom};  // held until the next request
        sent++;
      end
      advance_cycle();
    end
    i_valid = 1'b0;
    for (cycles = 0; cycles < drain_limit && (s1_valid || exp_q.size() != 0); cycles++) begin
      advance_cycle();
    end
    if (sent < num_requests || s1_valid || exp_q.size() != 0) begin
      report_error("timeout while waiting for requests or results");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule
